// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := cache_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR)
SIM_ARGS   := +verilator+error+limit+100
PASS_MSG   := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== include/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Organisation of the banked cache.
`define CACHE_NUM_BANKS     4
`define CACHE_SETS_PER_BANK 4
`define CACHE_NUM_WAYS      2
`define CACHE_BLOCK_WORDS   4

// Word address, data and request tag widths.
`define CACHE_ADDR_W        12
`define CACHE_DATA_W        32
`define CACHE_TAG_W         4

// Address fields, low to high: offset, bank, set, address tag.
`define CACHE_OFF_W         2
`define CACHE_BANK_W        2
`define CACHE_SET_W         2
`define CACHE_ATAG_W        6
`define CACHE_WAY_W         1

`endif

// ==== rtl/bank_dispatch.sv ====
`include "cache_cfg.svh"

module bank_dispatch (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         req,
  input  cache_ops_pkg::mem_op         req_op,
  input  logic [`CACHE_ADDR_W-1:0]     req_addr,
  input  logic [`CACHE_DATA_W-1:0]     req_wdata,
  input  logic [`CACHE_TAG_W-1:0]      req_tag,
  input  logic [`CACHE_NUM_BANKS-1:0]  bank_busy,
  output logic                         stall,
  output logic [`CACHE_NUM_BANKS-1:0]  bank_req,
  output cache_ops_pkg::mem_op         bank_op,
  output logic [`CACHE_ADDR_W-1:0]     bank_addr,
  output logic [`CACHE_DATA_W-1:0]     bank_wdata,
  output logic [`CACHE_TAG_W-1:0]      bank_tag
);
  import cache_ops_pkg::*;

  logic                     held_valid;
  mem_op                    held_op;
  logic [`CACHE_ADDR_W-1:0] held_addr;
  logic [`CACHE_DATA_W-1:0] held_wdata;
  logic [`CACHE_TAG_W-1:0]  held_tag;
  logic [`CACHE_BANK_W-1:0] target;
  logic                     issue;

  assign target = held_addr[`CACHE_OFF_W +: `CACHE_BANK_W];
  assign issue  = held_valid && !bank_busy[target];
  assign stall  = held_valid && bank_busy[target]; // Holder frees in the issue cycle.

  always_comb begin
    bank_req = '0;
    if (issue) bank_req[target] = 1'b1;
  end

  assign bank_op    = held_op;
  assign bank_addr  = held_addr;
  assign bank_wdata = held_wdata;
  assign bank_tag   = held_tag;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) held_valid <= 1'b0;
    else if (req && !stall) held_valid <= 1'b1;
    else if (issue) held_valid <= 1'b0;
  end

  always_ff @(posedge CLK) begin
    if (req && !stall) begin
      held_op    <= req_op;
      held_addr  <= req_addr;
      held_wdata <= req_wdata;
      held_tag   <= req_tag;
    end
  end

endmodule

// ==== rtl/cache_bank.sv ====
`include "cache_cfg.svh"

module cache_bank (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       bank_req,
  input  cache_ops_pkg::mem_op       bank_op,
  input  logic [`CACHE_ADDR_W-1:0]   bank_addr,
  input  logic [`CACHE_DATA_W-1:0]   bank_wdata,
  input  logic [`CACHE_TAG_W-1:0]    bank_tag,
  output logic                       bank_busy,
  output logic                       resp_req,
  output cache_types_pkg::bank_resp  resp_data,
  input  logic                       resp_gnt,
  output logic                       mem_need,
  output cache_types_pkg::mem_req    mem_data,
  input  logic                       mem_gnt,
  input  logic                       mem_rvalid,
  input  logic [`CACHE_DATA_W-1:0]   mem_rdata
);
  import cache_types_pkg::*;
  import cache_ops_pkg::*;

  localparam logic [`CACHE_OFF_W-1:0] LAST_WORD = `CACHE_OFF_W'(`CACHE_BLOCK_WORDS - 1);

  cache_set                      bank [`CACHE_SETS_PER_BANK];
  logic [`CACHE_WAY_W-1:0]       victim_ptr [`CACHE_SETS_PER_BANK];
  bank_state                     state;
  mshr_reg                       mshr;
  logic [`CACHE_OFF_W-1:0]       cnt;
  logic                          rd_wait;
  logic [`CACHE_BLOCK_WORDS-1:0][`CACHE_DATA_W-1:0] pull_buf;
  logic [`CACHE_BLOCK_WORDS-1:0][`CACHE_DATA_W-1:0] install_blk;
  logic [`CACHE_DATA_W-1:0]      rdata;

  logic [`CACHE_OFF_W-1:0]       m_off;
  logic [`CACHE_SET_W-1:0]       m_set;
  logic [`CACHE_ATAG_W-1:0]      m_atag;
  logic                          hit;
  logic [`CACHE_WAY_W-1:0]       hit_way;
  logic [`CACHE_WAY_W-1:0]       victim;
  logic                          victim_dirty;
  cache_frame                    victim_frame;

  assign m_off  = mshr.addr[`CACHE_OFF_W-1:0];
  assign m_set  = mshr.addr[`CACHE_OFF_W + `CACHE_BANK_W +: `CACHE_SET_W];
  assign m_atag = mshr.addr[`CACHE_ADDR_W-1 -: `CACHE_ATAG_W];

  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      if (bank[m_set][w].valid && (bank[m_set][w].atag == m_atag)) begin
        hit     = 1'b1;
        hit_way = `CACHE_WAY_W'(w);
      end
    end
  end

  assign victim       = victim_ptr[m_set];
  assign victim_dirty = bank[m_set][victim].valid && bank[m_set][victim].dirty;
  assign victim_frame = bank[m_set][mshr.way]; // Way is latched by the time of eject.

  // Store word merged over the pulled block.
  always_comb begin
    install_blk = pull_buf;
    if (mshr.op == OP_WRITE) install_blk[m_off] = mshr.wdata;
  end

  assign bank_busy = (state != IDLE);
  assign resp_req  = (state == RESPOND);

  always_comb begin
    resp_data.tag   = mshr.tag;
    resp_data.rdata = rdata;
  end

  assign mem_need = (state == VICTIM_EJECT) || ((state == BLOCK_PULL) && !rd_wait);

  always_comb begin
    mem_data.we    = (state == VICTIM_EJECT);
    mem_data.wdata = victim_frame.block[cnt];
    if (state == VICTIM_EJECT) begin
      mem_data.addr = {victim_frame.atag,
                       mshr.addr[`CACHE_ADDR_W-`CACHE_ATAG_W-1:`CACHE_OFF_W], cnt};
    end else begin
      mem_data.addr = {mshr.addr[`CACHE_ADDR_W-1:`CACHE_OFF_W], cnt};
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state      <= IDLE;
      cnt        <= '0;
      rd_wait    <= 1'b0;
      victim_ptr <= '{default: '0};
      bank       <= '{default: '0};
    end else begin
      case (state)
        IDLE: begin
          if (bank_req) state <= LOOKUP;
        end
        LOOKUP: begin
          if (hit) begin
            if (mshr.op == OP_WRITE) begin
              bank[m_set][hit_way].block[m_off] <= mshr.wdata;
              bank[m_set][hit_way].dirty        <= 1'b1;
            end
            state <= RESPOND;
          end else begin
            victim_ptr[m_set] <= victim + 1'b1; // Round robin per set.
            cnt               <= '0;
            state             <= victim_dirty ? VICTIM_EJECT : BLOCK_PULL;
          end
        end
        VICTIM_EJECT: begin
          if (mem_gnt) begin
            cnt <= cnt + 1'b1;
            if (cnt == LAST_WORD) state <= BLOCK_PULL;
          end
        end
        BLOCK_PULL: begin
          if (mem_gnt) rd_wait <= 1'b1;
          // Read data is broadcast, only the bank with a read in flight takes it.
          if (rd_wait && mem_rvalid) begin
            rd_wait <= 1'b0;
            cnt     <= cnt + 1'b1;
            if (cnt == LAST_WORD) state <= INSTALL;
          end
        end
        INSTALL: begin
          bank[m_set][mshr.way].valid <= 1'b1;
          bank[m_set][mshr.way].dirty <= (mshr.op == OP_WRITE);
          bank[m_set][mshr.way].atag  <= m_atag;
          bank[m_set][mshr.way].block <= install_blk;
          state                       <= RESPOND;
        end
        RESPOND: begin
          if (resp_gnt) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if ((state == IDLE) && bank_req) begin
      mshr.op    <= bank_op;
      mshr.addr  <= bank_addr;
      mshr.wdata <= bank_wdata;
      mshr.tag   <= bank_tag;
    end
    if (state == LOOKUP) begin
      if (!hit) mshr.way <= victim;
      else if (mshr.op == OP_WRITE) rdata <= mshr.wdata; // Writes echo the stored value.
      else rdata <= bank[m_set][hit_way].block[m_off];
    end
    if ((state == BLOCK_PULL) && rd_wait && mem_rvalid) pull_buf[cnt] <= mem_rdata;
    if (state == INSTALL) rdata <= install_blk[m_off];
  end

endmodule

// ==== rtl/cache_ops_pkg.sv ====
package cache_ops_pkg;

  // Bank FSM.
  // IDLE         waits for an issue from the dispatcher
  // LOOKUP       tag compare, hit access
  // VICTIM_EJECT writes a dirty victim back word by word
  // BLOCK_PULL   reads the missing block word by word
  // INSTALL      writes the pulled block into the victim way
  // RESPOND      holds the response until the merger grants it
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    VICTIM_EJECT,
    BLOCK_PULL,
    INSTALL,
    RESPOND
  } bank_state;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } mem_op;

endpackage

// ==== rtl/cache_top.sv ====
`include "cache_cfg.svh"

module cache_top (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      req,
  input  cache_ops_pkg::mem_op      req_op,
  input  logic [`CACHE_ADDR_W-1:0]  req_addr,
  input  logic [`CACHE_DATA_W-1:0]  req_wdata,
  input  logic [`CACHE_TAG_W-1:0]   req_tag,
  output logic                      stall,
  output logic                      resp_valid,
  output logic [`CACHE_TAG_W-1:0]   resp_tag,
  output logic [`CACHE_DATA_W-1:0]  resp_rdata,
  output logic                      mem_strobe,
  output logic                      mem_we,
  output logic [`CACHE_ADDR_W-1:0]  mem_addr,
  output logic [`CACHE_DATA_W-1:0]  mem_wdata,
  input  logic                      mem_rvalid,
  input  logic [`CACHE_DATA_W-1:0]  mem_rdata
);
  import cache_types_pkg::*;

  logic [`CACHE_NUM_BANKS-1:0] bank_busy;
  logic [`CACHE_NUM_BANKS-1:0] bank_req;
  cache_ops_pkg::mem_op        bank_op;
  logic [`CACHE_ADDR_W-1:0]    bank_addr;
  logic [`CACHE_DATA_W-1:0]    bank_wdata;
  logic [`CACHE_TAG_W-1:0]     bank_tag;

  logic [`CACHE_NUM_BANKS-1:0] resp_req;
  logic [`CACHE_NUM_BANKS-1:0] resp_gnt;
  bank_resp                    resp_data [`CACHE_NUM_BANKS];
  bank_resp                    resp_out;

  logic [`CACHE_NUM_BANKS-1:0] mem_need;
  logic [`CACHE_NUM_BANKS-1:0] mem_gnt;
  mem_req                      mem_data [`CACHE_NUM_BANKS];
  mem_req                      mem_out;
  logic                        mem_hold;

  assign resp_tag   = resp_out.tag;
  assign resp_rdata = resp_out.rdata;
  assign mem_we     = mem_out.we;
  assign mem_addr   = mem_out.addr;
  assign mem_wdata  = mem_out.wdata;
  assign mem_hold   = mem_strobe && !mem_out.we; // Read on the bus, answer not back yet.

  bank_dispatch u_dispatch (
    .CLK, .nRST, .req, .req_op, .req_addr, .req_wdata, .req_tag,
    .bank_busy, .stall, .bank_req, .bank_op, .bank_addr, .bank_wdata, .bank_tag
  );

  for (genvar b = 0; b < `CACHE_NUM_BANKS; b++) begin : g_bank
    cache_bank u_bank (
      .CLK, .nRST,
      .bank_req   (bank_req[b]),
      .bank_op, .bank_addr, .bank_wdata, .bank_tag,
      .bank_busy  (bank_busy[b]),
      .resp_req   (resp_req[b]),
      .resp_data  (resp_data[b]),
      .resp_gnt   (resp_gnt[b]),
      .mem_need   (mem_need[b]),
      .mem_data   (mem_data[b]),
      .mem_gnt    (mem_gnt[b]),
      .mem_rvalid,
      .mem_rdata
    );
  end

  rr_merge #(.payload_t(bank_resp), .N(`CACHE_NUM_BANKS)) u_resp_merge (
    .CLK, .nRST, .in_req(resp_req), .in_data(resp_data), .hold(1'b0),
    .gnt(resp_gnt), .out_valid(resp_valid), .out_data(resp_out)
  );

  rr_merge #(.payload_t(mem_req), .N(`CACHE_NUM_BANKS)) u_mem_merge (
    .CLK, .nRST, .in_req(mem_need), .in_data(mem_data), .hold(mem_hold),
    .gnt(mem_gnt), .out_valid(mem_strobe), .out_data(mem_out)
  );

endmodule

// ==== rtl/cache_types_pkg.sv ====
`include "cache_cfg.svh"

package cache_types_pkg;

  // One block frame.
  typedef struct packed {
    logic                                             valid;
    logic                                             dirty;
    logic [`CACHE_ATAG_W-1:0]                         atag;
    logic [`CACHE_BLOCK_WORDS-1:0][`CACHE_DATA_W-1:0] block;
  } cache_frame;

  typedef cache_frame [`CACHE_NUM_WAYS-1:0] cache_set;

  // Outstanding request of a bank, victim way filled in on a miss.
  typedef struct packed {
    cache_ops_pkg::mem_op     op;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_DATA_W-1:0] wdata;
    logic [`CACHE_TAG_W-1:0]  tag;
    logic [`CACHE_WAY_W-1:0]  way;
  } mshr_reg;

  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]  tag;
    logic [`CACHE_DATA_W-1:0] rdata;
  } bank_resp;

  typedef struct packed {
    logic                     we;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_DATA_W-1:0] wdata;
  } mem_req;

endpackage

// ==== rtl/rr_merge.sv ====
module rr_merge #(
  parameter type payload_t = logic,
  parameter int  N         = 4
) (
  input  logic         CLK,
  input  logic         nRST,
  input  logic [N-1:0] in_req,
  input  payload_t     in_data [N],
  input  logic         hold,
  output logic [N-1:0] gnt,
  output logic         out_valid,
  output payload_t     out_data
);

  localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

  logic [IDX_W-1:0] ptr;
  logic [IDX_W-1:0] sel;
  logic             found;
  logic             grant_ok;

  // First requester at or after the pointer wins.
  always_comb begin
    sel   = ptr;
    found = 1'b0;
    for (int k = N - 1; k >= 0; k--) begin
      if (in_req[(int'(ptr) + k) % N]) begin
        sel   = IDX_W'((int'(ptr) + k) % N);
        found = 1'b1;
      end
    end
  end

  assign grant_ok = found && !hold;

  always_comb begin
    gnt = '0;
    if (grant_ok) gnt[sel] = 1'b1;
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
      ptr       <= '0;
    end else begin
      out_valid <= grant_ok;
      if (grant_ok) ptr <= (int'(sel) == N - 1) ? '0 : sel + 1'b1; // Winner drops to last.
    end
  end

  always_ff @(posedge CLK) begin
    if (grant_ok) out_data <= in_data[sel];
  end

endmodule

// ==== sources.f ====
+incdir+include
rtl/cache_ops_pkg.sv
rtl/cache_types_pkg.sv
rtl/bank_dispatch.sv
rtl/rr_merge.sv
rtl/cache_bank.sv
rtl/cache_top.sv
testbench/cache_asserts.sv
testbench/cache_tb.sv

// ==== testbench/cache_asserts.sv ====
`include "cache_cfg.svh"

module confirm_bank_replacement (
  input logic                                             CLK,
  input logic                                             nRST,
  input cache_ops_pkg::bank_state                         state,
  input cache_types_pkg::mshr_reg                         mshr,
  input cache_types_pkg::cache_set                        bank [`CACHE_SETS_PER_BANK],
  input cache_types_pkg::cache_frame                      victim_frame,
  input logic [`CACHE_BLOCK_WORDS-1:0][`CACHE_DATA_W-1:0] pull_buf,
  input logic [`CACHE_SET_W-1:0]                          m_set,
  input logic [`CACHE_OFF_W-1:0]                          m_off,
  input logic [`CACHE_ATAG_W-1:0]                         m_atag,
  input logic                                             hit,
  input logic [`CACHE_WAY_W-1:0]                          hit_way
);
  import cache_types_pkg::*;
  import cache_ops_pkg::*;

  logic [`CACHE_BLOCK_WORDS-1:0][`CACHE_DATA_W-1:0] merged_blk; // Pulled block plus store.
  logic fail_block     = 1'b0;
  logic fail_write_hit = 1'b0;
  logic failed;

  always_comb begin
    merged_blk = pull_buf;
    if (mshr.op == OP_WRITE) merged_blk[m_off] = mshr.wdata;
  end

  assign failed = fail_block || fail_write_hit;

  a_install_block: assert property (@(posedge CLK) disable iff (!nRST)
    (state == INSTALL) |=> victim_frame.valid && (victim_frame.atag == $past(m_atag))
                           && (victim_frame.block == $past(merged_blk)))
    else begin
      $error("Installed frame does not hold the pulled block.");
      fail_block = 1'b1;
    end

  a_write_hit: assert property (@(posedge CLK) disable iff (!nRST)
    (state == LOOKUP && hit && mshr.op == OP_WRITE)
      |=> bank[m_set][hit_way].dirty && (bank[m_set][hit_way].block[m_off] == $past(mshr.wdata)))
    else begin
      $error("Write hit did not leave the stored word in place.");
      fail_write_hit = 1'b1;
    end

endmodule

bind cache_bank confirm_bank_replacement u_replace_check (
  .CLK, .nRST, .state, .mshr, .bank, .victim_frame, .pull_buf,
  .m_set, .m_off, .m_atag, .hit, .hit_way
);

// ==== testbench/cache_tb.sv ====
`include "cache_cfg.svh"

module cache_tb;
  import cache_ops_pkg::*;

  localparam int MEM_WORDS  = 1 << `CACHE_ADDR_W;
  localparam int NUM_TAGS   = 1 << `CACHE_TAG_W;
  localparam int WAIT_LIMIT = 1000;

  logic                     CLK;
  logic                     nRST;
  logic                     req;
  mem_op                    req_op;
  logic [`CACHE_ADDR_W-1:0] req_addr;
  logic [`CACHE_DATA_W-1:0] req_wdata;
  logic [`CACHE_TAG_W-1:0]  req_tag;
  logic                     stall;
  logic                     resp_valid;
  logic [`CACHE_TAG_W-1:0]  resp_tag;
  logic [`CACHE_DATA_W-1:0] resp_rdata;
  logic                     mem_strobe;
  logic                     mem_we;
  logic [`CACHE_ADDR_W-1:0] mem_addr;
  logic [`CACHE_DATA_W-1:0] mem_wdata;
  logic                     mem_rvalid;
  logic [`CACHE_DATA_W-1:0] mem_rdata;

  logic [`CACHE_DATA_W-1:0] mem [MEM_WORDS];
  logic [`CACHE_DATA_W-1:0] shadow [MEM_WORDS];
  logic                     written [MEM_WORDS];
  int                       pend_writes [MEM_WORDS]; // Accepted writes not yet answered.
  logic                     busy_tag [NUM_TAGS];
  logic [`CACHE_DATA_W-1:0] want_data [NUM_TAGS];
  logic [`CACHE_ADDR_W-1:0] tag_addr [NUM_TAGS];
  mem_op                    tag_op [NUM_TAGS];
  int                       done_order [NUM_TAGS];
  int                       resp_count;
  int                       eject_count;
  logic [`CACHE_ADDR_W-1:0] rd_addr;
  logic [31:0]              rand_state;

  cache_top UUT (.*);

  always #4 CLK = ~CLK;

  function automatic logic [31:0] lcg(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [`CACHE_DATA_W-1:0] expected_data(input logic [`CACHE_ADDR_W-1:0] a);
    if (written[a]) return shadow[a];
    return lcg(32'(a)); // Initial memory pattern.
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int t = 0; t < NUM_TAGS; t++) n += int'(busy_tag[t]);
    return n;
  endfunction

  function automatic logic bank_assert_fired();
    return UUT.g_bank[0].u_bank.u_replace_check.failed
        || UUT.g_bank[1].u_bank.u_replace_check.failed
        || UUT.g_bank[2].u_bank.u_replace_check.failed
        || UUT.g_bank[3].u_bank.u_replace_check.failed;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) fail_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, want));
  endtask

  task automatic wait_tag_free(input logic [`CACHE_TAG_W-1:0] tag);
    int n;
    n = 0;
    while (busy_tag[tag]) begin
      @(posedge CLK);
      #1;
      n++;
      if (n > WAIT_LIMIT) fail_run($sformatf("Tag %0d did not complete in time.", tag));
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (outstanding() != 0) begin
      @(posedge CLK);
      #1;
      n++;
      if (n > WAIT_LIMIT) fail_run("Outstanding requests did not complete in time.");
    end
  endtask

  task automatic wait_mem_strobe();
    int n;
    n = 0;
    while (!mem_strobe) begin
      @(posedge CLK);
      #1;
      n++;
      if (n > WAIT_LIMIT) fail_run("The memory port stayed idle too long.");
    end
  endtask

  // Called 1 unit after a rising edge and returns 1 unit after the accepting edge.
  task automatic send_request(input mem_op op, input logic [`CACHE_ADDR_W-1:0] a,
                              input logic [`CACHE_DATA_W-1:0] data,
                              input logic [`CACHE_TAG_W-1:0] tag);
    int n;
    n = 0;
    while (stall) begin
      @(posedge CLK);
      #1;
      n++;
      if (n > WAIT_LIMIT) fail_run("Stall stayed high too long.");
    end
    req       = 1'b1;
    req_op    = op;
    req_addr  = a;
    req_wdata = data;
    req_tag   = tag;
    busy_tag[tag] = 1'b1;
    tag_addr[tag] = a;
    tag_op[tag]   = op;
    if (op == OP_WRITE) begin
      shadow[a]  = data;
      written[a] = 1'b1;
      pend_writes[a]++;
    end
    want_data[tag] = expected_data(a);
    @(posedge CLK);
    #1;
    req = 1'b0;
  endtask

  // Main memory model that answers a read one cycle after its strobe.
  always begin
    @(negedge CLK);
    if (mem_strobe && mem_we) begin
      eject_count++;
      if (pend_writes[mem_addr] == 0) check_value("mem_wdata", mem_wdata, expected_data(mem_addr));
      mem[mem_addr] = mem_wdata;
    end else if (mem_strobe) begin
      rd_addr = mem_addr;
      @(posedge CLK);
      #1;
      mem_rvalid = 1'b1;
      mem_rdata  = mem[rd_addr];
      @(posedge CLK);
      #1;
      mem_rvalid = 1'b0;
    end
  end

  always @(negedge CLK) begin
    if (resp_valid) begin
      if (!busy_tag[resp_tag]) fail_run($sformatf("Response for idle tag %0d.", resp_tag));
      check_value("resp_rdata", resp_rdata, want_data[resp_tag]);
      if (tag_op[resp_tag] == OP_WRITE) pend_writes[tag_addr[resp_tag]]--;
      resp_count++;
      done_order[resp_tag] = resp_count;
      busy_tag[resp_tag]   = 1'b0;
    end
    if (bank_assert_fired()) fail_run("A replacement assertion in a cache bank failed.");
  end

  initial begin
    logic [31:0]             r;
    logic [`CACHE_TAG_W-1:0] tag;
    CLK         = 1'b0;
    nRST        = 1'b0;
    req         = 1'b0;
    req_op      = OP_READ;
    req_addr    = '0;
    req_wdata   = '0;
    req_tag     = '0;
    mem_rvalid  = 1'b0;
    mem_rdata   = '0;
    resp_count  = 0;
    eject_count = 0;
    rand_state  = 32'h438f;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a]         = lcg(32'(a));
      shadow[a]      = '0;
      written[a]     = 1'b0;
      pend_writes[a] = 0;
    end
    for (int t = 0; t < NUM_TAGS; t++) begin
      busy_tag[t]   = 1'b0;
      done_order[t] = 0;
    end
    repeat (8) @(posedge CLK);
    #1;
    nRST = 1'b1;

    repeat (4) begin
      @(negedge CLK);
      check_value("stall", 32'(stall), 32'h0);
      check_value("resp_valid", 32'(resp_valid), 32'h0);
      check_value("mem_strobe", 32'(mem_strobe), 32'h0);
    end
    @(posedge CLK);
    #1;

    // Cold reads in every bank.
    send_request(OP_READ, 12'h000, '0, 4'd0);
    send_request(OP_READ, 12'h015, '0, 4'd1);
    send_request(OP_READ, 12'h02a, '0, 4'd2);
    send_request(OP_READ, 12'h03f, '0, 4'd3);
    wait_idle();

    send_request(OP_WRITE, 12'h104, 32'hcafe_0001, 4'd4);
    send_request(OP_READ, 12'h104, '0, 4'd5);
    wait_idle();

    // Three blocks on bank 2, set 1.
    eject_count = 0;
    send_request(OP_WRITE, 12'h419, 32'h4a11_0001, 4'd1);
    send_request(OP_WRITE, 12'h459, 32'h4a11_0002, 4'd2);
    send_request(OP_WRITE, 12'h49a, 32'h4a11_0003, 4'd3);
    wait_idle();
    if (eject_count == 0) fail_run("No dirty block was written back to memory.");
    send_request(OP_READ, 12'h419, '0, 4'd4);
    send_request(OP_READ, 12'h459, '0, 4'd5);
    send_request(OP_READ, 12'h49a, '0, 4'd6);
    wait_idle();

    for (int i = 0; i < 200; i++) begin
      rand_state = lcg(rand_state);
      r          = rand_state;
      tag        = 4'(8 + (i % 4));
      wait_tag_free(tag);
      send_request(r[24] ? OP_WRITE : OP_READ, {4'h0, r[15:8]}, lcg(r), tag);
    end
    wait_idle();

    // A hit in bank 1 overtakes a miss in bank 0.
    send_request(OP_READ, 12'h804, '0, 4'd1);
    wait_idle();
    send_request(OP_READ, 12'h800, '0, 4'd2);
    wait_mem_strobe();
    send_request(OP_READ, 12'h804, '0, 4'd3);
    check_value("stall", 32'(stall), 32'h0);
    wait_idle();
    if (done_order[3] > done_order[2]) fail_run("The bank 1 hit finished after the bank 0 miss.");

    $display("NO ERRORS");
    $finish;
  end

endmodule
